// File: hdl/core_pkg.sv
// register widths, instruction-class and alu-operation enums, major opcode constants
package core_pkg;

  // RV64I register width and register index width
  localparam int xlen = 64;
  localparam int reg_addr_w = 5;

  // major opcode classes kept by the decoder
  typedef enum logic [2:0] {
    cls_reg,
    cls_imm,
    cls_regw,
    cls_immw,
    cls_lui,
    cls_auipc,
    cls_none
  } inst_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // major opcodes, bits [6:0] of the instruction word
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;

endpackage

// File: hdl/inst_port.sv
// four-phase req/ack instruction receiver with word and pc latch and decode pulse
`timescale 1ns/1ps

module inst_port (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      inst_req_i,
  input  logic [31:0]               inst_data_i,
  input  logic [core_pkg::xlen-1:0] inst_pc_i,
  output logic                      inst_ack_o,
  output logic                      dec_valid_o,
  output logic [31:0]               dec_inst_o,
  output logic [core_pkg::xlen-1:0] dec_pc_o
);

  logic take;

  // new request seen while ack is still low
  assign take = inst_req_i && !inst_ack_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inst_ack_o  <= 1'b0;
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= take;
      if (take) begin
        inst_ack_o <= 1'b1;
      end else if (!inst_req_i && inst_ack_o) begin
        // return to zero once the feeder drops req
        inst_ack_o <= 1'b0;
      end
    end
  end

  // hold word and pc so the outside bus may move after ack
  always_ff @(posedge clk_i) begin
    if (take) begin
      dec_inst_o <= inst_data_i;
      dec_pc_o   <= inst_pc_i;
    end
  end

endmodule

// File: hdl/id_stage.sv
// decode stage with field split, class and alu-op decode, bypassed operands and immediates
`timescale 1ns/1ps

module id_stage (
  input  logic                            dec_valid_i,
  input  logic [31:0]                     dec_inst_i,
  input  logic [core_pkg::xlen-1:0]       dec_pc_i,
  output logic [core_pkg::reg_addr_w-1:0] rs1_addr_o,
  output logic [core_pkg::reg_addr_w-1:0] rs2_addr_o,
  input  logic [core_pkg::xlen-1:0]       rs1_data_i,
  input  logic [core_pkg::xlen-1:0]       rs2_data_i,
  input  logic                            wb_we_i,
  input  logic [core_pkg::reg_addr_w-1:0] wb_addr_i,
  input  logic [core_pkg::xlen-1:0]       wb_data_i,
  output logic                            id_valid_o,
  output core_pkg::inst_class_e           id_class_o,
  output core_pkg::alu_op_e               id_alu_op_o,
  output logic [core_pkg::xlen-1:0]       id_op1_o,
  output logic [core_pkg::xlen-1:0]       id_op2_o,
  output logic                            id_rd_we_o,
  output logic [core_pkg::reg_addr_w-1:0] id_rd_addr_o,
  output logic                            id_illegal_o
);

  import core_pkg::*;

  logic [6:0]            opcode;
  logic [reg_addr_w-1:0] rd;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_u;
  logic [xlen-1:0]       shamt;
  logic [xlen-1:0]       rs1_val;
  logic [xlen-1:0]       rs2_val;
  logic                  is_reg;
  logic                  is_imm;
  logic                  shift_imm;
  inst_class_e           inst_class;

  assign opcode     = dec_inst_i[6:0];
  assign rd         = dec_inst_i[11:7];
  assign funct3     = dec_inst_i[14:12];
  assign funct7     = dec_inst_i[31:25];
  assign rs1_addr_o = dec_inst_i[19:15];
  assign rs2_addr_o = dec_inst_i[24:20];

  assign imm_i = {{(xlen-12){dec_inst_i[31]}}, dec_inst_i[31:20]};
  assign imm_u = {{(xlen-32){dec_inst_i[31]}}, dec_inst_i[31:12], 12'b0};

  always_comb begin
    unique case (opcode)
      opc_op:        inst_class = cls_reg;
      opc_op_imm:    inst_class = cls_imm;
      opc_op_32:     inst_class = cls_regw;
      opc_op_imm_32: inst_class = cls_immw;
      opc_lui:       inst_class = cls_lui;
      opc_auipc:     inst_class = cls_auipc;
      default:       inst_class = cls_none;
    endcase
  end

  assign is_reg    = (inst_class == cls_reg) || (inst_class == cls_regw);
  assign is_imm    = (inst_class == cls_imm) || (inst_class == cls_immw);
  assign shift_imm = is_imm && (funct3[1:0] == 2'b01);

  // word shifts take 5 bits of shamt
  assign shamt = (inst_class == cls_immw) ? {{(xlen-5){1'b0}}, dec_inst_i[24:20]}
                                          : {{(xlen-6){1'b0}}, dec_inst_i[25:20]};

  // bit 30 picks sub and sra
  always_comb begin
    id_alu_op_o = alu_add;
    if (is_reg || is_imm) begin
      unique case (funct3)
        3'b000: id_alu_op_o = (is_reg && funct7[5]) ? alu_sub : alu_add;
        3'b001: id_alu_op_o = alu_sll;
        3'b010: id_alu_op_o = alu_slt;
        3'b011: id_alu_op_o = alu_sltu;
        3'b100: id_alu_op_o = alu_xor;
        3'b101: id_alu_op_o = funct7[5] ? alu_sra : alu_srl;
        3'b110: id_alu_op_o = alu_or;
        3'b111: id_alu_op_o = alu_and;
      endcase
    end
  end

  // x0 never takes the bypass because wb_we excludes it
  assign rs1_val = (wb_we_i && (wb_addr_i == rs1_addr_o)) ? wb_data_i : rs1_data_i;
  assign rs2_val = (wb_we_i && (wb_addr_i == rs2_addr_o)) ? wb_data_i : rs2_data_i;

  always_comb begin
    unique case (inst_class)
      cls_reg, cls_imm, cls_regw, cls_immw: id_op1_o = rs1_val;
      cls_auipc:                            id_op1_o = dec_pc_i;
      default:                              id_op1_o = '0;
    endcase
  end

  always_comb begin
    unique case (inst_class)
      cls_reg, cls_regw: id_op2_o = rs2_val;
      cls_imm, cls_immw: id_op2_o = shift_imm ? shamt : imm_i;
      cls_lui, cls_auipc: id_op2_o = imm_u;
      default:           id_op2_o = '0;
    endcase
  end

  assign id_valid_o   = dec_valid_i;
  assign id_class_o   = inst_class;
  assign id_rd_addr_o = rd;
  assign id_rd_we_o   = dec_valid_i && (inst_class != cls_none) && (rd != '0);
  assign id_illegal_o = dec_valid_i && (inst_class == cls_none);

endmodule

// File: hdl/regfile.sv
// 32 x 64-bit integer register file with two read ports and one write port
`timescale 1ns/1ps

module regfile (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [core_pkg::reg_addr_w-1:0] rs1_addr_i,
  input  logic [core_pkg::reg_addr_w-1:0] rs2_addr_i,
  output logic [core_pkg::xlen-1:0]       rs1_data_o,
  output logic [core_pkg::xlen-1:0]       rs2_data_o,
  input  logic                            we_i,
  input  logic [core_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [core_pkg::xlen-1:0]       wdata_i
);

  import core_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  // entry 0 is cleared by reset and never written
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // asynchronous reads
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

// File: hdl/ex_stage.sv
// execute stage with 64-bit and word alu plus execute and write-back registers
`timescale 1ns/1ps

module ex_stage (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            id_valid_i,
  input  core_pkg::inst_class_e           id_class_i,
  input  core_pkg::alu_op_e               id_alu_op_i,
  input  logic [core_pkg::xlen-1:0]       id_op1_i,
  input  logic [core_pkg::xlen-1:0]       id_op2_i,
  input  logic                            id_rd_we_i,
  input  logic [core_pkg::reg_addr_w-1:0] id_rd_addr_i,
  input  logic                            id_illegal_i,
  output logic                            wb_valid_o,
  output logic                            wb_we_o,
  output logic [core_pkg::reg_addr_w-1:0] wb_addr_o,
  output logic [core_pkg::xlen-1:0]       wb_data_o,
  output logic                            wb_illegal_o
);

  import core_pkg::*;

  logic                  ex_valid;
  logic                  ex_rd_we;
  logic                  ex_illegal;
  inst_class_e           ex_class;
  alu_op_e               ex_alu_op;
  logic [xlen-1:0]       ex_op1;
  logic [xlen-1:0]       ex_op2;
  logic [reg_addr_w-1:0] ex_rd_addr;
  logic [xlen-1:0]       res64;
  logic [31:0]           res32;
  logic [xlen-1:0]       result;
  logic                  is_w;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid   <= 1'b0;
      ex_rd_we   <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      ex_valid   <= id_valid_i;
      ex_rd_we   <= id_rd_we_i;
      ex_illegal <= id_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_class   <= id_class_i;
    ex_alu_op  <= id_alu_op_i;
    ex_op1     <= id_op1_i;
    ex_op2     <= id_op2_i;
    ex_rd_addr <= id_rd_addr_i;
  end

  always_comb begin
    unique case (ex_alu_op)
      alu_add:  res64 = ex_op1 + ex_op2;
      alu_sub:  res64 = ex_op1 - ex_op2;
      alu_sll:  res64 = ex_op1 << ex_op2[5:0];
      alu_slt:  res64 = {{(xlen-1){1'b0}}, ($signed(ex_op1) < $signed(ex_op2))};
      alu_sltu: res64 = {{(xlen-1){1'b0}}, (ex_op1 < ex_op2)};
      alu_xor:  res64 = ex_op1 ^ ex_op2;
      alu_srl:  res64 = ex_op1 >> ex_op2[5:0];
      alu_sra:  res64 = $signed(ex_op1) >>> ex_op2[5:0];
      alu_or:   res64 = ex_op1 | ex_op2;
      alu_and:  res64 = ex_op1 & ex_op2;
      default:  res64 = '0;
    endcase
  end

  // word forms only use 5 shift bits
  always_comb begin
    unique case (ex_alu_op)
      alu_add: res32 = ex_op1[31:0] + ex_op2[31:0];
      alu_sub: res32 = ex_op1[31:0] - ex_op2[31:0];
      alu_sll: res32 = ex_op1[31:0] << ex_op2[4:0];
      alu_srl: res32 = ex_op1[31:0] >> ex_op2[4:0];
      alu_sra: res32 = $signed(ex_op1[31:0]) >>> ex_op2[4:0];
      default: res32 = res64[31:0];
    endcase
  end

  assign is_w   = (ex_class == cls_regw) || (ex_class == cls_immw);
  assign result = is_w ? {{(xlen-32){res32[31]}}, res32} : res64;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o   <= 1'b0;
      wb_we_o      <= 1'b0;
      wb_illegal_o <= 1'b0;
    end else begin
      wb_valid_o   <= ex_valid && !ex_illegal;
      wb_we_o      <= ex_rd_we;
      wb_illegal_o <= ex_illegal;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_addr_o <= ex_rd_addr;
    wb_data_o <= result;
  end

endmodule

// File: hdl/core_top.sv
// rv64i integer core top with instruction port, decode, register file and execute
`timescale 1ns/1ps

module core_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            inst_req_i,
  input  logic [31:0]                     inst_data_i,
  input  logic [core_pkg::xlen-1:0]       inst_pc_i,
  output logic                            inst_ack_o,
  output logic                            wb_valid_o,
  output logic [core_pkg::reg_addr_w-1:0] wb_rd_o,
  output logic [core_pkg::xlen-1:0]       wb_data_o,
  output logic                            ill_inst_o
);

  import core_pkg::*;

  logic                  dec_valid;
  logic [31:0]           dec_inst;
  logic [xlen-1:0]       dec_pc;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic                  id_valid;
  inst_class_e           id_class;
  alu_op_e               id_alu_op;
  logic [xlen-1:0]       id_op1;
  logic [xlen-1:0]       id_op2;
  logic                  id_rd_we;
  logic [reg_addr_w-1:0] id_rd_addr;
  logic                  id_illegal;
  logic                  wb_we;

  inst_port inst_port_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inst_req_i  (inst_req_i),
    .inst_data_i (inst_data_i),
    .inst_pc_i   (inst_pc_i),
    .inst_ack_o  (inst_ack_o),
    .dec_valid_o (dec_valid),
    .dec_inst_o  (dec_inst),
    .dec_pc_o    (dec_pc)
  );

  id_stage id_stage_i (
    .dec_valid_i  (dec_valid),
    .dec_inst_i   (dec_inst),
    .dec_pc_i     (dec_pc),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .wb_we_i      (wb_we),
    .wb_addr_i    (wb_rd_o),
    .wb_data_i    (wb_data_o),
    .id_valid_o   (id_valid),
    .id_class_o   (id_class),
    .id_alu_op_o  (id_alu_op),
    .id_op1_o     (id_op1),
    .id_op2_o     (id_op2),
    .id_rd_we_o   (id_rd_we),
    .id_rd_addr_o (id_rd_addr),
    .id_illegal_o (id_illegal)
  );

  regfile regfile_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_we),
    .waddr_i    (wb_rd_o),
    .wdata_i    (wb_data_o)
  );

  // write-back register feeds regfile, bypass and the retire ports
  ex_stage ex_stage_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .id_valid_i   (id_valid),
    .id_class_i   (id_class),
    .id_alu_op_i  (id_alu_op),
    .id_op1_i     (id_op1),
    .id_op2_i     (id_op2),
    .id_rd_we_i   (id_rd_we),
    .id_rd_addr_i (id_rd_addr),
    .id_illegal_i (id_illegal),
    .wb_valid_o   (wb_valid_o),
    .wb_we_o      (wb_we),
    .wb_addr_o    (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .wb_illegal_o (ill_inst_o)
  );

endmodule

// File: verif/core_tb.sv
// testbench for core_top with four-phase feeder, vector file reader and in-order write-back checker
`timescale 1ns/1ps

module core_tb;

  localparam int num_vec      = 26;
  localparam int reset_cycles = 5;
  localparam int clk_period   = 4;

  logic        clk_i;
  logic        reset_i;
  logic        inst_req_i;
  logic [31:0] inst_data_i;
  logic [63:0] inst_pc_i;
  logic        inst_ack_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [63:0] wb_data_o;
  logic        ill_inst_o;

  // pc, word, kind, rd and value per vector
  logic [63:0] vec_mem [num_vec*5];
  int          mon_idx  = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          missing  = 0;

  core_top core_top_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inst_req_i  (inst_req_i),
    .inst_data_i (inst_data_i),
    .inst_pc_i   (inst_pc_i),
    .inst_ack_o  (inst_ack_o),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .ill_inst_o  (ill_inst_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period/2) clk_i = ~clk_i;
  end

  // four-phase transfer starting and ending 1 ns after a rising edge
  task automatic send_inst(input logic [63:0] pc, input logic [31:0] word);
    inst_pc_i   = pc;
    inst_data_i = word;
    inst_req_i  = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!inst_ack_o);
    inst_req_i = 1'b0;
    do begin
      @(posedge clk_i);
      #1;
    end while (inst_ack_o);
  endtask

  // true when the next word reads this vector's rd
  function automatic bit feeds_next(input int idx);
    logic [4:0]  rd;
    logic [31:0] nxt;
    if (idx + 1 >= num_vec) begin
      return 1'b0;
    end
    rd  = vec_mem[idx*5+1][11:7];
    nxt = vec_mem[(idx+1)*5+1][31:0];
    return (rd != 5'd0) && ((nxt[19:15] == rd) || (nxt[24:20] == rd));
  endfunction

  // pairs one retire or unsupported report with the next vector
  task automatic check_event();
    logic [63:0] exp_kind;
    logic [63:0] exp_rd;
    logic [63:0] exp_val;
    bit          ok;
    ok = 1'b1;
    assert (mon_idx < num_vec) else begin
      $display("retire or unsupported report seen after the last vector");
      fail_cnt++;
    end
    if (mon_idx < num_vec) begin
      exp_kind = vec_mem[mon_idx*5+2];
      exp_rd   = vec_mem[mon_idx*5+3];
      exp_val  = vec_mem[mon_idx*5+4];
      assert (!(wb_valid_o && ill_inst_o)) else begin
        $display("wb_valid_o and ill_inst_o high together for vector %0d", mon_idx);
        ok = 1'b0;
      end
      assert (ill_inst_o == exp_kind[0]) else begin
        $display("ERROR ill_inst_o expected 0x%h got 0x%h", exp_kind[0], ill_inst_o);
        ok = 1'b0;
      end
      if (exp_kind == 64'd0 && wb_valid_o) begin
        assert (wb_rd_o == exp_rd[4:0]) else begin
          $display("ERROR wb_rd_o expected 0x%h got 0x%h", exp_rd[4:0], wb_rd_o);
          ok = 1'b0;
        end
        assert (wb_data_o == exp_val) else begin
          $display("ERROR wb_data_o expected 0x%h got 0x%h", exp_val, wb_data_o);
          ok = 1'b0;
        end
      end
      $display("vector %0d pc 0x%h %s", mon_idx, vec_mem[mon_idx*5], ok ? "ok" : "failed");
      if (ok) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      mon_idx++;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!reset_i && (wb_valid_o || ill_inst_o)) begin
      check_event();
    end
  end

  initial begin
    void'($urandom(87));
    reset_i     = 1'b1;
    inst_req_i  = 1'b0;
    inst_data_i = '0;
    inst_pc_i   = '0;
    $readmemh("verif/core_vectors.txt", vec_mem);
    repeat (reset_cycles) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      send_inst(vec_mem[i*5], vec_mem[i*5+1][31:0]);
      // dependent pairs go back to back through the bypass
      if (!feeds_next(i)) begin
        repeat ($urandom_range(3)) begin
          @(posedge clk_i);
          #1;
        end
      end
    end
    // drain the last result and watch for stray reports
    repeat (8) @(posedge clk_i);
    assert (mon_idx == num_vec) else begin
      $display("%0d vectors never retired or reported", num_vec - mon_idx);
      missing = num_vec - mon_idx;
    end
    $display("vectors passed %0d failed %0d missing %0d", pass_cnt, fail_cnt, missing);
    if (fail_cnt == 0 && missing == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (num_vec*12 + reset_cycles) @(posedge clk_i);
    $display("watchdog expired with %0d of %0d vectors checked", mon_idx, num_vec);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: verif/core_vectors.txt
// columns: pc, instruction word, kind (0 retire, 1 unsupported), rd, value
// all hex, unsupported lines carry rd and value of zero
1000 00500093 0 01 0000000000000005 // addi x1, x0, 5
1004 ffd00113 0 02 fffffffffffffffd // addi x2, x0, -3
1008 002081b3 0 03 0000000000000002 // add x3, x1, x2
100c 40208233 0 04 0000000000000008 // sub x4, x1, x2
1010 001122b3 0 05 0000000000000001 // slt x5, x2, x1
1014 00113333 0 06 0000000000000000 // sltu x6, x2, x1
1018 02109393 0 07 0000000a00000000 // slli x7, x1, 33
101c 40415413 0 08 ffffffffffffffff // srai x8, x2, 4
1020 03c15493 0 09 000000000000000f // srli x9, x2, 60
1024 fff0c513 0 0a fffffffffffffffa // xori x10, x1, -1
1028 0040e5b3 0 0b 000000000000000d // or x11, x1, x4
102c 0065f613 0 0c 0000000000000004 // andi x12, x11, 6
1030 00160693 0 0d 0000000000000005 // addi x13, x12, 1
1034 00c68733 0 0e 0000000000000009 // add x14, x13, x12
1038 800007b7 0 0f ffffffff80000000 // lui x15, 0x80000
103c fff7881b 0 10 000000007fffffff // addiw x16, x15, -1
1040 001808bb 0 11 ffffffff80000004 // addw x17, x16, x1
1044 4048d91b 0 12 fffffffff8000000 // sraiw x18, x17, 4
1048 410089bb 0 13 ffffffff80000006 // subw x19, x1, x16
104c 12345a17 0 14 000000001234604c // auipc x20, 0x12345
1050 00708013 0 00 000000000000000c // addi x0, x1, 7
1054 00106ab3 0 15 0000000000000005 // or x21, x0, x1
1058 0000b183 1 00 0000000000000000 // ld x3, 0(x1)
105c 00208463 1 00 0000000000000000 // beq x1, x2, +8
1060 00000073 1 00 0000000000000000 // ecall
1064 00018b33 0 16 0000000000000002 // add x22, x3, x0

// File: filelist.f
hdl/core_pkg.sv
hdl/inst_port.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/ex_stage.sv
hdl/core_top.sv
verif/core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench

TOP       ?= core_tb
VERILATOR ?= verilator
FILELIST  ?= filelist.f
SRCS      ?= $(shell cat $(FILELIST))
SIM_FLAGS ?= --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS)
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) $(SRCS)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
